/* gat_coef_top.f */
+incdir+verilog
verilog/gat_coef_pkg.sv
verilog/dot_if.sv
verilog/attn_weight_regs.sv
verilog/dot_product_tree.sv
verilog/coef_relu_stage.sv
verilog/gat_coef_top.sv
tb/tb_clkgen.sv
tb/tb_gat_coef.sv

/* run_sim.sh */
#!/bin/sh
# Build the GAT coefficient testbench with Verilator, run it, and judge the result from the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_gat_coef -f gat_coef_top.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
  echo "result: pass"
  exit 0
fi
echo "result: fail"
exit 1

/* tb/tb_clkgen.sv */
// free-running testbench clock source, instantiate once and take the clock from clk_o
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int HALF_PERIOD_NS = 5
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

endmodule

/* tb/tb_gat_coef.sv */
// directed testbench for gat_coef_top, run as top module tb_gat_coef with the project file list
`timescale 1ns/1ps
`include "gat_coef_settings.svh"

module tb_gat_coef;

  localparam int         NF          = `GAT_NUM_FEAT;
  localparam int         AW          = `GAT_AXI_ADDR_WIDTH;
  localparam int         TIMEOUT     = 200;
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef logic [AW-1:0] addr_t;

  logic                        clk;
  logic                        rst_n;
  logic                        s_awvalid_i;
  logic                        s_awready_o;
  addr_t                       s_awaddr_i;
  logic                        s_wvalid_i;
  logic                        s_wready_o;
  logic [31:0]                 s_wdata_i;
  logic [3:0]                  s_wstrb_i;
  logic                        s_bvalid_o;
  logic                        s_bready_i;
  logic [1:0]                  s_bresp_o;
  logic                        s_arvalid_i;
  logic                        s_arready_o;
  addr_t                       s_araddr_i;
  logic                        s_rvalid_o;
  logic                        s_rready_i;
  logic [31:0]                 s_rdata_o;
  logic [1:0]                  s_rresp_o;
  logic                        wh_valid_i;
  logic                        wh_ready_o;
  logic [NF*`GAT_WH_WIDTH-1:0] wh_row_i;
  logic                        wh_src_i;
  logic                        coef_valid_o;
  logic                        coef_ready_i;
  gat_coef_pkg::coef_t         coef_o;

  // weights as last written, plus the model's held source product
  int                          wgt [2*NF];
  gat_coef_pkg::dot_t          held_src;
  gat_coef_pkg::coef_t         exp_q [$];
  gat_coef_pkg::coef_t         rx_q [$];
  int                          exp_total;
  int                          tests;
  int                          checks;
  int                          errors;
  logic [31:0]                 rng_state;

  tb_clkgen clkgen_i (.clk_o(clk));

  gat_coef_top gat_coef_top_i (.*);

  // ====================================================================
  // helpers
  // ====================================================================
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'(next_rand() % 32'(hi - lo + 1));
  endfunction

  function automatic gat_coef_pkg::wh_row_t random_row();
    gat_coef_pkg::wh_row_t r;
    for (int k = 0; k < NF; k++) begin
      r[k] = gat_coef_pkg::wh_elem_t'(rand_range(-512, 511));
    end
    return r;
  endfunction

  function automatic gat_coef_pkg::wh_row_t const_row(input int v);
    gat_coef_pkg::wh_row_t r;
    for (int k = 0; k < NF; k++) begin
      r[k] = gat_coef_pkg::wh_elem_t'(v);
    end
    return r;
  endfunction

  task automatic check_coef(input string name, input gat_coef_pkg::coef_t got,
                            input gat_coef_pkg::coef_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got 0x%02h expected 0x%02h", name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got 0x%01h expected 0x%01h", name, got, exp);
    end
  endtask

  task automatic report_fail(input string what);
    errors++;
    $display("ERROR at %0t ns: %s", $time, what);
  endtask

  task automatic end_test(input string name, input int start);
    tests++;
    if (errors == start) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - start);
    end
  endtask

  // ====================================================================
  // reference model, one coefficient per row
  // ====================================================================
  task automatic model_row(input gat_coef_pkg::wh_row_t row, input logic src);
    gat_coef_pkg::dot_pair_t d;
    int s;
    int n;
    int total;
    s = 0;
    n = 0;
    for (int k = 0; k < NF; k++) begin
      s += wgt[k] * int'(row[k]);
      n += wgt[NF+k] * int'(row[k]);
    end
    d.src_flag = src;
    d.src_dot  = gat_coef_pkg::dot_t'(s);
    d.nbr_dot  = gat_coef_pkg::dot_t'(n);
    if (d.src_flag) begin
      held_src = d.src_dot;
    end
    total = int'(held_src) + int'(d.nbr_dot);
    // ReLU, then keep the top bits
    if (total < 0) begin
      exp_q.push_back('0);
    end else begin
      exp_q.push_back(gat_coef_pkg::coef_t'(total >>> `GAT_COEF_SHIFT));
    end
    exp_total++;
  endtask

  // ====================================================================
  // AXI4-Lite and stream drivers
  // ====================================================================
  task automatic axi_write(input addr_t addr, input logic [31:0] data, output logic [1:0] resp);
    logic aw_go;
    logic w_go;
    logic aw_done;
    logic w_done;
    int   waited;
    aw_done = 1'b0;
    w_done  = 1'b0;
    waited  = 0;
    @(negedge clk);
    s_awvalid_i = 1'b1;
    s_awaddr_i  = addr;
    s_wvalid_i  = 1'b1;
    s_wdata_i   = data;
    s_wstrb_i   = 4'h1;
    // ready is registered, so its value now decides the next edge
    while (!(aw_done && w_done) && waited < TIMEOUT) begin
      aw_go = s_awvalid_i && s_awready_o;
      w_go  = s_wvalid_i && s_wready_o;
      @(negedge clk);
      waited++;
      if (aw_go) begin
        aw_done     = 1'b1;
        s_awvalid_i = 1'b0;
      end
      if (w_go) begin
        w_done     = 1'b1;
        s_wvalid_i = 1'b0;
      end
    end
    if (!(aw_done && w_done)) begin
      report_fail("write address or data never accepted");
    end
    waited = 0;
    while (!s_bvalid_o && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!s_bvalid_o) begin
      report_fail("no write response");
    end
    resp = s_bresp_o;
  endtask

  task automatic axi_read(input addr_t addr, output logic [31:0] data, output logic [1:0] resp);
    int waited;
    waited = 0;
    @(negedge clk);
    s_arvalid_i = 1'b1;
    s_araddr_i  = addr;
    while (!s_arready_o && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!s_arready_o) begin
      report_fail("read address never accepted");
    end
    @(negedge clk);
    s_arvalid_i = 1'b0;
    waited      = 0;
    while (!s_rvalid_o && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!s_rvalid_o) begin
      report_fail("no read data");
    end
    data = s_rdata_o;
    resp = s_rresp_o;
  endtask

  task automatic write_weights();
    logic [1:0] resp;
    for (int i = 0; i < 2 * NF; i++) begin
      axi_write(addr_t'(`GAT_REG_A_BASE + 4 * i), 32'(wgt[i]) & 32'h0000_00ff, resp);
      check_resp("s_bresp_o", resp, RESP_OKAY);
    end
  endtask

  task automatic present_row(input gat_coef_pkg::wh_row_t row, input logic src);
    @(negedge clk);
    wh_valid_i = 1'b1;
    wh_row_i   = row;
    wh_src_i   = src;
    model_row(row, src);
  endtask

  task automatic wait_accept();
    int waited;
    waited = 0;
    while (!wh_ready_o && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!wh_ready_o) begin
      report_fail("wh_ready_o never rose for an offered row");
    end
    @(posedge clk);
  endtask

  task automatic send_row(input gat_coef_pkg::wh_row_t row, input logic src);
    present_row(row, src);
    wait_accept();
  endtask

  task automatic stream_idle();
    @(negedge clk);
    wh_valid_i = 1'b0;
    wh_src_i   = 1'b0;
  endtask

  task automatic drain_and_compare();
    int waited;
    waited = 0;
    while (rx_q.size() < exp_q.size() && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    // a short quiet window catches surplus coefficients
    repeat (8) @(negedge clk);
    while (exp_q.size() > 0) begin
      if (rx_q.size() == 0) begin
        report_fail("expected coefficient never arrived");
        void'(exp_q.pop_front());
      end else begin
        check_coef("coef_o", rx_q.pop_front(), exp_q.pop_front());
      end
    end
    if (rx_q.size() != 0) begin
      report_fail("coefficients arrived that no row produced");
      rx_q.delete();
    end
  endtask

  // coefficient transfers seen on the output port
  always @(posedge clk) begin
    if (rst_n && coef_valid_o && coef_ready_i) begin
      rx_q.push_back(coef_o);
    end
  end

  // ====================================================================
  // directed tests
  // ====================================================================
  task automatic test_registers();
    int          start;
    logic [31:0] data;
    logic [1:0]  resp;
    start = errors;
    axi_read(addr_t'(`GAT_REG_COUNT), data, resp);
    check_word("s_rdata_o", data, 32'h0);
    check_resp("s_rresp_o", resp, RESP_OKAY);
    wgt = '{3, -2, 7, 1, -4, 5, 2, -6};
    write_weights();
    for (int i = 0; i < 2 * NF; i++) begin
      axi_read(addr_t'(`GAT_REG_A_BASE + 4 * i), data, resp);
      check_word("s_rdata_o", data, 32'(wgt[i]) & 32'h0000_00ff);
      check_resp("s_rresp_o", resp, RESP_OKAY);
    end
    axi_read(addr_t'('h24), data, resp);
    check_resp("s_rresp_o", resp, RESP_SLVERR);
    axi_write(addr_t'('h30), 32'h1, resp);
    check_resp("s_bresp_o", resp, RESP_SLVERR);
    end_test("registers", start);
  endtask

  task automatic test_single_subgraph();
    int start;
    start = errors;
    wgt = '{40, -25, 33, 17, -12, 50, 28, -9};
    write_weights();
    send_row(random_row(), 1'b1);
    for (int i = 0; i < 3; i++) begin
      send_row(random_row(), 1'b0);
    end
    stream_idle();
    drain_and_compare();
    end_test("single_subgraph", start);
  endtask

  task automatic test_relu();
    int start;
    start = errors;
    // negative weights on positive rows give negative sums
    wgt = '{-100, -100, -100, -100, -100, -100, -100, -100};
    write_weights();
    send_row(const_row(500), 1'b1);
    send_row(const_row(300), 1'b0);
    stream_idle();
    drain_and_compare();
    // near the top of the dot range
    wgt = '{127, 127, 127, 127, 127, 127, 127, 127};
    write_weights();
    send_row(const_row(511), 1'b1);
    send_row(const_row(100), 1'b0);
    stream_idle();
    drain_and_compare();
    end_test("relu", start);
  endtask

  task automatic test_source_switch();
    int start;
    start = errors;
    wgt = '{60, -45, 30, 20, 25, -35, 50, 15};
    write_weights();
    for (int g = 0; g < 2; g++) begin
      send_row(random_row(), 1'b1);
      send_row(random_row(), 1'b0);
      send_row(random_row(), 1'b0);
    end
    stream_idle();
    drain_and_compare();
    end_test("source_switch", start);
  endtask

  task automatic test_back_pressure();
    int start;
    start = errors;
    @(negedge clk);
    coef_ready_i = 1'b0;
    for (int i = 0; i < `GAT_FIFO_DEPTH; i++) begin
      send_row(random_row(), i == 0);
    end
    present_row(random_row(), 1'b0);
    repeat (16) begin
      @(negedge clk);
      if (wh_ready_o) begin
        report_fail("wh_ready_o high while the output FIFO is full");
      end
    end
    if (!coef_valid_o) begin
      report_fail("coef_valid_o low with entries in the FIFO");
    end
    check_coef("coef_o", coef_o, exp_q[0]);
    coef_ready_i = 1'b1;
    wait_accept();
    for (int i = 0; i < 3; i++) begin
      send_row(random_row(), 1'b0);
    end
    stream_idle();
    drain_and_compare();
    end_test("back_pressure", start);
  endtask

  task automatic test_counter();
    int          start;
    logic [31:0] data;
    logic [1:0]  resp;
    start = errors;
    for (int i = 0; i < 2 * NF; i++) begin
      wgt[i] = rand_range(-64, 63);
    end
    write_weights();
    for (int i = 0; i < 40; i++) begin
      send_row(random_row(), (i == 0) || (next_rand() % 5 == 0));
    end
    stream_idle();
    drain_and_compare();
    axi_read(addr_t'(`GAT_REG_COUNT), data, resp);
    check_word("s_rdata_o", data, 32'(exp_total));
    check_resp("s_rresp_o", resp, RESP_OKAY);
    end_test("counter", start);
  endtask

  initial begin
    rst_n        = 1'b0;
    s_awvalid_i  = 1'b0;
    s_awaddr_i   = '0;
    s_wvalid_i   = 1'b0;
    s_wdata_i    = '0;
    s_wstrb_i    = '0;
    s_bready_i   = 1'b1;
    s_arvalid_i  = 1'b0;
    s_araddr_i   = '0;
    s_rready_i   = 1'b1;
    wh_valid_i   = 1'b0;
    wh_row_i     = '0;
    wh_src_i     = 1'b0;
    coef_ready_i = 1'b1;
    held_src     = '0;
    exp_total    = 0;
    tests        = 0;
    checks       = 0;
    errors       = 0;
    rng_state    = 32'd69;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    test_registers();
    test_single_subgraph();
    test_relu();
    test_source_switch();
    test_back_pressure();
    test_counter();

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* verilog/attn_weight_regs.sv */
// AXI4-Lite register block with the attention weights and the emitted-coefficient counter
`timescale 1ns/1ps
`include "gat_coef_settings.svh"

module attn_weight_regs (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            s_awvalid_i,
  output logic                            s_awready_o,
  input  logic [`GAT_AXI_ADDR_WIDTH-1:0]  s_awaddr_i,
  input  logic                            s_wvalid_i,
  output logic                            s_wready_o,
  input  logic [31:0]                     s_wdata_i,
  input  logic [3:0]                      s_wstrb_i,
  output logic                            s_bvalid_o,
  input  logic                            s_bready_i,
  output logic [1:0]                      s_bresp_o,
  input  logic                            s_arvalid_i,
  output logic                            s_arready_o,
  input  logic [`GAT_AXI_ADDR_WIDTH-1:0]  s_araddr_i,
  output logic                            s_rvalid_o,
  input  logic                            s_rready_i,
  output logic [31:0]                     s_rdata_o,
  output logic [1:0]                      s_rresp_o,
  input  logic                            coef_pop_i,
  output gat_coef_pkg::a_vec_t            a_src_o,
  output gat_coef_pkg::a_vec_t            a_nbr_o
);

  localparam int         ADDR_W      = `GAT_AXI_ADDR_WIDTH;
  localparam int         NF          = `GAT_NUM_FEAT;
  localparam int         NW          = 2 * NF;
  localparam int         IDX_W       = $clog2(NW);
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  gat_coef_pkg::a_elem_t a_reg [NW];
  logic                  aw_full;
  logic                  w_full;
  logic [ADDR_W-1:0]     aw_addr_q;
  logic [7:0]            w_byte_q;
  logic                  w_strb_q;
  logic                  do_wr;
  logic [31:0]           coef_cnt;
  logic [31:0]           rd_word;
  logic [1:0]            rd_resp;

  function automatic logic weight_hit(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] off;
    off = addr - ADDR_W'(`GAT_REG_A_BASE);
    return off < ADDR_W'(4 * NW);
  endfunction

  function automatic logic [IDX_W-1:0] weight_idx(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] off;
    off = addr - ADDR_W'(`GAT_REG_A_BASE);
    return off[IDX_W+1:2];
  endfunction

  // ==================================================================
  // write channel
  // ==================================================================
  assign s_awready_o = !aw_full;
  assign s_wready_o  = !w_full;
  // address and data may come in either order
  assign do_wr       = aw_full && w_full && !s_bvalid_o;

  always_ff @(posedge clk) begin
    if (s_awvalid_i && s_awready_o) begin
      aw_addr_q <= s_awaddr_i;
    end
    if (s_wvalid_i && s_wready_o) begin
      w_byte_q <= s_wdata_i[7:0];
      w_strb_q <= s_wstrb_i[0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      aw_full    <= 1'b0;
      w_full     <= 1'b0;
      s_bvalid_o <= 1'b0;
      s_bresp_o  <= RESP_OKAY;
      for (int i = 0; i < NW; i++) begin
        a_reg[i] <= '0;
      end
    end else begin
      if (s_awvalid_i && s_awready_o) begin
        aw_full <= 1'b1;
      end
      if (s_wvalid_i && s_wready_o) begin
        w_full <= 1'b1;
      end
      if (do_wr) begin
        aw_full    <= 1'b0;
        w_full     <= 1'b0;
        s_bvalid_o <= 1'b1;
        // counter is read only, so only weights accept writes
        if (weight_hit(aw_addr_q)) begin
          s_bresp_o <= RESP_OKAY;
          if (w_strb_q) begin
            a_reg[weight_idx(aw_addr_q)] <= w_byte_q;
          end
        end else begin
          s_bresp_o <= RESP_SLVERR;
        end
      end else if (s_bready_i) begin
        s_bvalid_o <= 1'b0;
      end
    end
  end

  // ==================================================================
  // read channel
  // ==================================================================
  assign s_arready_o = !s_rvalid_o;

  always_comb begin
    rd_word = '0;
    rd_resp = RESP_SLVERR;
    if (weight_hit(s_araddr_i)) begin
      rd_word = {{(32 - `GAT_A_WIDTH){1'b0}}, a_reg[weight_idx(s_araddr_i)]};
      rd_resp = RESP_OKAY;
    end else if (s_araddr_i == ADDR_W'(`GAT_REG_COUNT)) begin
      rd_word = coef_cnt;
      rd_resp = RESP_OKAY;
    end
  end

  always_ff @(posedge clk) begin
    if (s_arvalid_i && s_arready_o) begin
      s_rdata_o <= rd_word;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s_rvalid_o <= 1'b0;
      s_rresp_o  <= RESP_OKAY;
    end else if (s_arvalid_i && s_arready_o) begin
      s_rvalid_o <= 1'b1;
      s_rresp_o  <= rd_resp;
    end else if (s_rready_i) begin
      s_rvalid_o <= 1'b0;
    end
  end

  // one count per coefficient leaving the output port
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      coef_cnt <= '0;
    end else if (coef_pop_i) begin
      coef_cnt <= coef_cnt + 32'd1;
    end
  end

  // weights 0..NF-1 source half, the rest neighbour half
  always_comb begin
    for (int k = 0; k < NF; k++) begin
      a_src_o[k] = a_reg[k];
      a_nbr_o[k] = a_reg[NF+k];
    end
  end

  a_b_after_write: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(s_bvalid_o) |-> $past(aw_full && w_full));

  a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o));

endmodule

/* verilog/coef_relu_stage.sv */
// source hold, ReLU and shift of each row result, output FIFO and input credit
`timescale 1ns/1ps
`include "gat_coef_settings.svh"

module coef_relu_stage (
  input  logic                clk,
  input  logic                rst_n,
  dot_if.consumer             dot,
  output logic                accept_o,
  output logic                coef_valid_o,
  input  logic                coef_ready_i,
  output gat_coef_pkg::coef_t coef_o,
  output logic                coef_pop_o
);

  localparam int DEPTH = `GAT_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;
  // accept edge to FIFO write edge
  localparam int LAT   = $clog2(`GAT_NUM_FEAT) + 1;

  gat_coef_pkg::dot_t             src_hold;
  gat_coef_pkg::dot_t             src_sel;
  logic signed [`GAT_DOT_WIDTH:0] sum;
  gat_coef_pkg::coef_t            coef_new;
  gat_coef_pkg::coef_t            mem [DEPTH];
  logic [PTR_W-1:0]               wr_ptr;
  logic [PTR_W-1:0]               rd_ptr;
  logic [CNT_W-1:0]               occ;
  logic [CNT_W-1:0]               occ_next;
  logic [CNT_W-1:0]               inflight;
  logic [CNT_W-1:0]               inflight_next;
  logic [LAT-1:0]                 acc_hist;
  logic                           fifo_wr;
  logic                           fifo_rd;

  // ==================================================================
  // coefficient
  // ==================================================================
  // a source row uses its own product right away
  assign src_sel  = (dot.valid && dot.res.src_flag) ? dot.res.src_dot : src_hold;
  assign sum      = src_sel + dot.res.nbr_dot;
  assign coef_new = sum[`GAT_DOT_WIDTH] ? '0 : gat_coef_pkg::coef_t'(sum >>> `GAT_COEF_SHIFT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      src_hold <= '0;
    end else if (dot.valid && dot.res.src_flag) begin
      src_hold <= dot.res.src_dot;
    end
  end

  // ==================================================================
  // output FIFO
  // ==================================================================
  assign fifo_wr      = dot.valid;
  assign fifo_rd      = coef_valid_o && coef_ready_i;
  assign coef_valid_o = (occ != '0);
  assign coef_o       = mem[rd_ptr];
  assign coef_pop_o   = fifo_rd;

  always_ff @(posedge clk) begin
    if (fifo_wr) begin
      mem[wr_ptr] <= coef_new;
    end
  end

  // ==================================================================
  // credit
  // ==================================================================
  // each accept cycle reserves one slot until its row would reach the FIFO
  assign occ_next      = occ + CNT_W'(fifo_wr) - CNT_W'(fifo_rd);
  assign inflight_next = inflight + CNT_W'(accept_o) - CNT_W'(acc_hist[LAT-1]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      occ      <= '0;
      inflight <= '0;
      acc_hist <= '0;
      accept_o <= 1'b0;
    end else begin
      if (fifo_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (fifo_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      occ      <= occ_next;
      inflight <= inflight_next;
      acc_hist <= {acc_hist[LAT-2:0], accept_o};
      accept_o <= ({1'b0, occ_next} + {1'b0, inflight_next}) < (CNT_W + 1)'(DEPTH);
    end
  end

  // the tree cannot stall, so the credit alone has to keep the FIFO from filling
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    fifo_wr |-> (occ < CNT_W'(DEPTH)) || fifo_rd);

  a_credit: assert property (@(posedge clk) disable iff (!rst_n)
    accept_o |=> ({1'b0, occ} + {1'b0, inflight}) <= (CNT_W + 1)'(DEPTH));

endmodule

/* verilog/dot_if.sv */
// result bus from the dot-product tree to the coefficient stage, one row result per valid cycle
`timescale 1ns/1ps

interface dot_if;

  logic                    valid;
  // source flag, source dot and neighbour dot of the same row
  gat_coef_pkg::dot_pair_t res;

  modport producer (
    output valid,
    output res
  );

  modport consumer (
    input valid,
    input res
  );

endinterface

/* verilog/dot_product_tree.sv */
// pipelined source and neighbour dot products of each accepted WH row, never stalls
`timescale 1ns/1ps
`include "gat_coef_settings.svh"

module dot_product_tree (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wh_valid_i,
  input  gat_coef_pkg::wh_row_t wh_row_i,
  input  logic                  wh_src_i,
  input  logic                  accept_i,
  input  gat_coef_pkg::a_vec_t  a_src_i,
  input  gat_coef_pkg::a_vec_t  a_nbr_i,
  dot_if.producer               dot
);

  localparam int NF     = `GAT_NUM_FEAT;
  localparam int LEVELS = $clog2(NF);
  // multiply register plus one register per adder level
  localparam int LAT    = LEVELS + 1;

  // heap layout with the root at node 1 and the products at NF .. 2*NF-1
  gat_coef_pkg::dot_t src_node [1:2*NF-1];
  gat_coef_pkg::dot_t nbr_node [1:2*NF-1];
  logic [LAT-1:0]     vld_q;
  logic [LAT-1:0]     flag_q;
  logic               take;

  assign take = wh_valid_i && accept_i;

  // ==================================================================
  // multiply and adder levels
  // ==================================================================
  always_ff @(posedge clk) begin
    // every internal node sums its two children of the level below
    for (int n = 1; n < NF; n++) begin
      src_node[n] <= src_node[2*n] + src_node[2*n+1];
      nbr_node[n] <= nbr_node[2*n] + nbr_node[2*n+1];
    end
    if (take) begin
      for (int k = 0; k < NF; k++) begin
        src_node[NF+k] <= $signed(a_src_i[k]) * $signed(wh_row_i[k]);
        nbr_node[NF+k] <= $signed(a_nbr_i[k]) * $signed(wh_row_i[k]);
      end
    end
  end

  // valid and source flag ride beside the sums
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q  <= '0;
      flag_q <= '0;
    end else begin
      vld_q  <= {vld_q[LAT-2:0], take};
      flag_q <= {flag_q[LAT-2:0], take && wh_src_i};
    end
  end

  assign dot.valid        = vld_q[LAT-1];
  assign dot.res.src_flag = flag_q[LAT-1];
  assign dot.res.src_dot  = src_node[1];
  assign dot.res.nbr_dot  = nbr_node[1];

  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    dot.valid == $past(take, LAT));

endmodule

/* verilog/gat_coef_pkg.sv */
// element, dot-product and coefficient types of the GAT coefficient engine, referenced by scope
`include "gat_coef_settings.svh"

package gat_coef_pkg;

  // scalar elements
  typedef logic signed [`GAT_A_WIDTH-1:0]   a_elem_t;
  typedef logic signed [`GAT_WH_WIDTH-1:0]  wh_elem_t;
  typedef logic signed [`GAT_DOT_WIDTH-1:0] dot_t;
  typedef logic [`GAT_COEF_WIDTH-1:0]       coef_t;

  // one half of the attention vector
  typedef a_elem_t [`GAT_NUM_FEAT-1:0] a_vec_t;

  // one row of WH, element 0 in the low bits
  typedef wh_elem_t [`GAT_NUM_FEAT-1:0] wh_row_t;

  // both dot products of one row plus its source marker
  typedef struct packed {
    logic src_flag;
    dot_t src_dot;
    dot_t nbr_dot;
  } dot_pair_t;

endpackage

/* verilog/gat_coef_settings.svh */
// shared sizes, widths and register offsets of the GAT coefficient engine, include where needed
`ifndef GAT_COEF_SETTINGS_SVH
`define GAT_COEF_SETTINGS_SVH

// ====================================================================
// data path
// ====================================================================
// features per WH row, power of two for the adder tree
`define GAT_NUM_FEAT        4
`define GAT_A_WIDTH         8
`define GAT_WH_WIDTH        12
`define GAT_DOT_WIDTH       19
`define GAT_COEF_WIDTH      8
// dot width minus coefficient width
`define GAT_COEF_SHIFT      11
`define GAT_FIFO_DEPTH      8

// ====================================================================
// AXI4-Lite register map
// ====================================================================
`define GAT_AXI_ADDR_WIDTH  6
// one weight per 32-bit word, byte lane 0
`define GAT_REG_A_BASE      'h00
`define GAT_REG_COUNT       'h20

`endif

/* verilog/gat_coef_top.sv */
// top level of the GAT coefficient engine with AXI4-Lite setup, WH row input and coefficient output
`timescale 1ns/1ps
`include "gat_coef_settings.svh"

module gat_coef_top (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     s_awvalid_i,
  output logic                                     s_awready_o,
  input  logic [`GAT_AXI_ADDR_WIDTH-1:0]           s_awaddr_i,
  input  logic                                     s_wvalid_i,
  output logic                                     s_wready_o,
  input  logic [31:0]                              s_wdata_i,
  input  logic [3:0]                               s_wstrb_i,
  output logic                                     s_bvalid_o,
  input  logic                                     s_bready_i,
  output logic [1:0]                               s_bresp_o,
  input  logic                                     s_arvalid_i,
  output logic                                     s_arready_o,
  input  logic [`GAT_AXI_ADDR_WIDTH-1:0]           s_araddr_i,
  output logic                                     s_rvalid_o,
  input  logic                                     s_rready_i,
  output logic [31:0]                              s_rdata_o,
  output logic [1:0]                               s_rresp_o,
  input  logic                                     wh_valid_i,
  output logic                                     wh_ready_o,
  input  logic [`GAT_NUM_FEAT*`GAT_WH_WIDTH-1:0]   wh_row_i,
  input  logic                                     wh_src_i,
  output logic                                     coef_valid_o,
  input  logic                                     coef_ready_i,
  output logic [`GAT_COEF_WIDTH-1:0]               coef_o
);

  gat_coef_pkg::a_vec_t a_src;
  gat_coef_pkg::a_vec_t a_nbr;
  logic                 accept;
  logic                 coef_pop;

  dot_if dot_i ();

  assign wh_ready_o = accept;

  attn_weight_regs attn_weight_regs_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .s_awvalid_i (s_awvalid_i),
    .s_awready_o (s_awready_o),
    .s_awaddr_i  (s_awaddr_i),
    .s_wvalid_i  (s_wvalid_i),
    .s_wready_o  (s_wready_o),
    .s_wdata_i   (s_wdata_i),
    .s_wstrb_i   (s_wstrb_i),
    .s_bvalid_o  (s_bvalid_o),
    .s_bready_i  (s_bready_i),
    .s_bresp_o   (s_bresp_o),
    .s_arvalid_i (s_arvalid_i),
    .s_arready_o (s_arready_o),
    .s_araddr_i  (s_araddr_i),
    .s_rvalid_o  (s_rvalid_o),
    .s_rready_i  (s_rready_i),
    .s_rdata_o   (s_rdata_o),
    .s_rresp_o   (s_rresp_o),
    .coef_pop_i  (coef_pop),
    .a_src_o     (a_src),
    .a_nbr_o     (a_nbr)
  );

  dot_product_tree dot_product_tree_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .wh_valid_i (wh_valid_i),
    .wh_row_i   (wh_row_i),
    .wh_src_i   (wh_src_i),
    .accept_i   (accept),
    .a_src_i    (a_src),
    .a_nbr_i    (a_nbr),
    .dot        (dot_i.producer)
  );

  coef_relu_stage coef_relu_stage_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .dot          (dot_i.consumer),
    .accept_o     (accept),
    .coef_valid_o (coef_valid_o),
    .coef_ready_i (coef_ready_i),
    .coef_o       (coef_o),
    .coef_pop_o   (coef_pop)
  );

endmodule
